// ==== Makefile ====
# Verilator build and run for the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_$(TOP)
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)

# the log decides pass or fail
run: compile
	./$(BUILD_DIR)/$(SIM_BIN) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/bp_hit_select.sv ====
`timescale 1ns/100ps

module bp_hit_select (
	bp_way_if.sel ways [bp_pkg::NUM_WAYS],
	output logic if_prediction,
	output logic [bp_pkg::PC_W-1:0] if_pbt,
	output logic id_present,
	output logic exe_hit,
	output logic [1:0] exe_way,
	output logic [bp_pkg::CTR_W-1:0] exe_ctr,
	output logic [bp_pkg::PC_W-1:0] exe_pbt
);

	// per-way results gathered into plain arrays
	logic [bp_pkg::NUM_WAYS-1:0] if_hit_v;
	logic [bp_pkg::PC_W-1:0] if_tgt_v [bp_pkg::NUM_WAYS];
	logic [bp_pkg::CTR_W-1:0] if_ctr_v [bp_pkg::NUM_WAYS];
	logic [bp_pkg::NUM_WAYS-1:0] id_hit_v;
	logic [bp_pkg::NUM_WAYS-1:0] exe_hit_v;
	logic [bp_pkg::PC_W-1:0] exe_tgt_v [bp_pkg::NUM_WAYS];
	logic [bp_pkg::CTR_W-1:0] exe_ctr_v [bp_pkg::NUM_WAYS];

	// interface array needs constant indices
	for (genvar g = 0; g < bp_pkg::NUM_WAYS; g++) begin : g_gather
		assign if_hit_v[g] = ways[g].if_hit;
		assign if_tgt_v[g] = ways[g].if_target;
		assign if_ctr_v[g] = ways[g].if_ctr;
		assign id_hit_v[g] = ways[g].id_hit;
		assign exe_hit_v[g] = ways[g].exe_hit;
		assign exe_tgt_v[g] = ways[g].exe_target;
		assign exe_ctr_v[g] = ways[g].exe_ctr;
	end

	////////////////////
	// IF select
	////////////////////

	// tags are unique in a set, so at most one way hits
	always_comb begin
		if_prediction = 1'b0;
		if_pbt = '0;
		for (int i = 0; i < bp_pkg::NUM_WAYS; i++) begin
			if (if_hit_v[i]) begin
				// predict taken from counter msb
				if_prediction = if_ctr_v[i][1];
				if_pbt = if_tgt_v[i];
			end
		end
	end

	////////////////////
	// ID presence
	////////////////////

	// any hit blocks a new allocation
	assign id_present = |id_hit_v;

	////////////////////
	// EXE select
	////////////////////

	// way index goes back to the controller for the counter write
	always_comb begin
		exe_hit = 1'b0;
		exe_way = 2'd0;
		exe_ctr = '0;
		exe_pbt = '0;
		for (int i = 0; i < bp_pkg::NUM_WAYS; i++) begin
			if (exe_hit_v[i]) begin
				exe_hit = 1'b1;
				exe_way = 2'(i);
				exe_ctr = exe_ctr_v[i];
				exe_pbt = exe_tgt_v[i];
			end
		end
	end

endmodule

// ==== design/bp_pkg.sv ====
package bp_pkg;

	////////////////////
	// table geometry
	////////////////////

	// word address width of the pipeline
	localparam int PC_W = 10;

	// low bits pick the set, high bits are the tag
	localparam int SET_W = 4;
	localparam int TAG_W = 6;

	localparam int NUM_SETS = 16;
	localparam int NUM_WAYS = 4;

	////////////////////
	// entry fields
	////////////////////

	// 2-bit saturating counter, bit 1 is the prediction
	localparam int CTR_W = 2;

	// new branches start weakly not taken
	localparam logic [CTR_W-1:0] CTR_BRANCH_INIT = 2'b01;
	// jumps always go, start strongly taken
	localparam logic [CTR_W-1:0] CTR_JUMP_INIT = 2'b11;

	////////////////////
	// EXE correction codes
	////////////////////

	// prediction was right, fetch keeps going with pc+1
	localparam logic [1:0] CORR_NONE = 2'b00;
	// wrongly taken, go back to the correct next instruction
	localparam logic [1:0] CORR_CNI = 2'b10;
	// wrongly not taken, go to the predicted target
	localparam logic [1:0] CORR_PBT = 2'b11;

	// one-hot branch type, msb first: beq bne blt bge bltu bgeu
	localparam int BTYPE_W = 6;

	// the pc seen either as one word or as tag over set
	typedef union packed {
		logic [PC_W-1:0] raw;
		struct packed {
			logic [TAG_W-1:0] tag;
			logic [SET_W-1:0] set;
		} fields;
	} pc_u;

endpackage

// ==== design/bp_update_ctrl.sv ====
`timescale 1ns/100ps

module bp_update_ctrl (
	input logic CLK,
	input logic nrst,
	input bp_pkg::pc_u id_pc,
	input logic [bp_pkg::PC_W-1:0] id_branchtarget,
	input logic id_is_jump,
	input logic id_is_btype,
	input bp_pkg::pc_u exe_pc,
	input logic exe_z,
	input logic exe_less,
	input logic [bp_pkg::BTYPE_W-1:0] exe_btype,
	input logic id_present,
	input logic exe_hit,
	input logic [1:0] exe_way,
	input logic [bp_pkg::CTR_W-1:0] exe_ctr,
	bp_way_if.ctrl ways [bp_pkg::NUM_WAYS],
	output logic [1:0] exe_correction,
	output logic [bp_pkg::PC_W-1:0] exe_cni,
	output logic flush
);

	logic [bp_pkg::SET_W-1:0] id_set;
	logic [bp_pkg::SET_W-1:0] exe_set;
	logic is_branch;
	logic taken;
	logic mispredict;
	logic alloc;
	logic upd;
	logic [bp_pkg::CTR_W-1:0] init_ctr;
	logic [bp_pkg::CTR_W-1:0] upd_ctr;
	logic [1:0] alloc_ptr;
	logic [bp_pkg::NUM_WAYS-1:0] alloc_oh;
	logic [bp_pkg::NUM_WAYS-1:0] upd_oh;
	// fifo replacement pointer per set
	logic [1:0] fifo_ptr [bp_pkg::NUM_SETS];
	// second flush cycle
	logic flush_q;

	assign id_set = id_pc.fields.set;
	assign exe_set = exe_pc.fields.set;

	////////////////////
	// branch outcome
	////////////////////

	// btype msb first: beq bne blt bge bltu bgeu
	// signed and unsigned compares share the less flag
	assign is_branch = |exe_btype;
	assign taken = (exe_btype[5] & exe_z)
		| (exe_btype[4] & ~exe_z)
		| ((exe_btype[3] | exe_btype[1]) & exe_less)
		| ((exe_btype[2] | exe_btype[0]) & ~exe_less);

	// only a resolved branch that hit the table is checked
	assign mispredict = exe_hit && is_branch && (taken != exe_ctr[1]);

	// taken means go to the stored target, else fall through
	assign exe_correction = !mispredict ? bp_pkg::CORR_NONE
		: (taken ? bp_pkg::CORR_PBT : bp_pkg::CORR_CNI);

	// fall-through address of the branch
	assign exe_cni = exe_pc.raw + 1'b1;

	////////////////////
	// flush
	////////////////////

	// mispredict flushes now and next cycle
	// a jump found in ID flushes next cycle
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			flush_q <= 1'b0;
		end else begin
			flush_q <= mispredict | id_is_jump;
		end
	end

	assign flush = mispredict | flush_q;

	////////////////////
	// allocation and update
	////////////////////

	// new branch or jump not yet in any way
	assign alloc = (id_is_btype | id_is_jump) & ~id_present;
	// allocation wins a same-cycle clash, update is dropped
	assign upd = exe_hit & is_branch & ~alloc;

	assign init_ctr = id_is_jump ? bp_pkg::CTR_JUMP_INIT : bp_pkg::CTR_BRANCH_INIT;

	// saturate at 11 going up, at 00 going down
	always_comb begin
		if (taken) begin
			upd_ctr = (exe_ctr == '1) ? exe_ctr : exe_ctr + 1'b1;
		end else begin
			upd_ctr = (exe_ctr == '0) ? exe_ctr : exe_ctr - 1'b1;
		end
	end

	assign alloc_ptr = fifo_ptr[id_set];

	// one-hot way enables
	always_comb begin
		for (int i = 0; i < bp_pkg::NUM_WAYS; i++) begin
			alloc_oh[i] = alloc && (alloc_ptr == 2'(i));
			upd_oh[i] = upd && (exe_way == 2'(i));
		end
	end

	// pointer moves on only when an entry is really written
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			for (int s = 0; s < bp_pkg::NUM_SETS; s++) begin
				fifo_ptr[s] <= 2'd0;
			end
		end else if (alloc) begin
			fifo_ptr[id_set] <= alloc_ptr + 2'd1;
		end
	end

	// same write data to every way, enables pick the target
	for (genvar g = 0; g < bp_pkg::NUM_WAYS; g++) begin : g_cmd
		assign ways[g].alloc_en = alloc_oh[g];
		assign ways[g].upd_en = upd_oh[g];
		assign ways[g].wr_set = alloc ? id_set : exe_set;
		assign ways[g].wr_tag = id_pc.fields.tag;
		assign ways[g].wr_target = id_branchtarget;
		assign ways[g].wr_ctr = alloc ? init_ctr : upd_ctr;
	end

endmodule

// ==== design/bp_way.sv ====
`timescale 1ns/100ps

module bp_way (
	input logic CLK,
	input logic nrst,
	input bp_pkg::pc_u if_pc,
	input bp_pkg::pc_u id_pc,
	input bp_pkg::pc_u exe_pc,
	bp_way_if.way port
);

	// one entry per set in this way
	logic valid [bp_pkg::NUM_SETS];
	logic [bp_pkg::TAG_W-1:0] tag_mem [bp_pkg::NUM_SETS];
	logic [bp_pkg::PC_W-1:0] target_mem [bp_pkg::NUM_SETS];
	logic [bp_pkg::CTR_W-1:0] ctr_mem [bp_pkg::NUM_SETS];

	// set fields of the three lookups
	logic [bp_pkg::SET_W-1:0] if_set;
	logic [bp_pkg::SET_W-1:0] id_set;
	logic [bp_pkg::SET_W-1:0] exe_set;

	assign if_set = if_pc.fields.set;
	assign id_set = id_pc.fields.set;
	assign exe_set = exe_pc.fields.set;

	////////////////////
	// lookups
	////////////////////

	// IF port, hit needs valid and matching tag
	assign port.if_hit = valid[if_set] && (tag_mem[if_set] == if_pc.fields.tag);
	assign port.if_target = target_mem[if_set];
	assign port.if_ctr = ctr_mem[if_set];

	// ID port, presence check before allocation
	assign port.id_hit = valid[id_set] && (tag_mem[id_set] == id_pc.fields.tag);

	// EXE port, feeds the outcome check
	assign port.exe_hit = valid[exe_set] && (tag_mem[exe_set] == exe_pc.fields.tag);
	assign port.exe_target = target_mem[exe_set];
	assign port.exe_ctr = ctr_mem[exe_set];

	////////////////////
	// writes
	////////////////////

	// valid bits, cleared on reset
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			for (int s = 0; s < bp_pkg::NUM_SETS; s++) begin
				valid[s] <= 1'b0;
			end
		end else if (port.alloc_en) begin
			valid[port.wr_set] <= 1'b1;
		end
	end

	// payload fields
	always_ff @(posedge CLK) begin
		if (port.alloc_en) begin
			// new entry overwrites whatever sat here
			tag_mem[port.wr_set] <= port.wr_tag;
			target_mem[port.wr_set] <= port.wr_target;
			ctr_mem[port.wr_set] <= port.wr_ctr;
		end else if (port.upd_en) begin
			// counter-only write, tag and target stay
			ctr_mem[port.wr_set] <= port.wr_ctr;
		end
	end

endmodule

// ==== design/bp_way_if.sv ====
`timescale 1ns/100ps

interface bp_way_if;

	// IF lookup results
	logic if_hit;
	logic [bp_pkg::PC_W-1:0] if_target;
	logic [bp_pkg::CTR_W-1:0] if_ctr;

	// ID lookup only needs presence
	logic id_hit;

	// EXE lookup results
	logic exe_hit;
	logic [bp_pkg::PC_W-1:0] exe_target;
	logic [bp_pkg::CTR_W-1:0] exe_ctr;

	// write commands
	// alloc writes the whole entry, upd only the counter
	logic alloc_en;
	logic upd_en;
	logic [bp_pkg::SET_W-1:0] wr_set;
	logic [bp_pkg::TAG_W-1:0] wr_tag;
	logic [bp_pkg::PC_W-1:0] wr_target;
	logic [bp_pkg::CTR_W-1:0] wr_ctr;

	// storage side
	modport way (
		output if_hit, if_target, if_ctr, id_hit, exe_hit, exe_target, exe_ctr,
		input alloc_en, upd_en, wr_set, wr_tag, wr_target, wr_ctr
	);

	// update controller side
	modport ctrl (
		output alloc_en, upd_en, wr_set, wr_tag, wr_target, wr_ctr
	);

	// hit selector side
	modport sel (
		input if_hit, if_target, if_ctr, id_hit, exe_hit, exe_target, exe_ctr
	);

endinterface

// ==== design/branch_predictor.sv ====
`timescale 1ns/100ps

module branch_predictor (
	input logic CLK,
	input logic nrst,

	// IF stage
	input logic [bp_pkg::PC_W-1:0] if_pc,

	// ID stage
	input logic [bp_pkg::PC_W-1:0] id_pc,
	input logic [bp_pkg::PC_W-1:0] id_branchtarget,
	input logic id_is_jump,
	input logic id_is_btype,

	// EXE stage, flags come from the ALU
	input logic [bp_pkg::PC_W-1:0] exe_pc,
	input logic exe_z,
	input logic exe_less,
	input logic [bp_pkg::BTYPE_W-1:0] exe_btype,

	// prediction for the fetch address
	output logic if_prediction,
	output logic [bp_pkg::PC_W-1:0] if_pbt,

	// next pc fix-up from EXE
	output logic [1:0] exe_correction,
	output logic [bp_pkg::PC_W-1:0] exe_pbt,
	output logic [bp_pkg::PC_W-1:0] exe_cni,
	output logic flush
);

	// pcs seen as tag over set
	bp_pkg::pc_u if_pc_u;
	bp_pkg::pc_u id_pc_u;
	bp_pkg::pc_u exe_pc_u;

	// merged lookup results for the controller
	logic id_present;
	logic exe_hit;
	logic [1:0] exe_way;
	logic [bp_pkg::CTR_W-1:0] exe_ctr;

	assign if_pc_u.raw = if_pc;
	assign id_pc_u.raw = id_pc;
	assign exe_pc_u.raw = exe_pc;

	// one bus per way
	bp_way_if way_bus [bp_pkg::NUM_WAYS] ();

	////////////////////
	// table ways
	////////////////////

	for (genvar g = 0; g < bp_pkg::NUM_WAYS; g++) begin : g_way
		bp_way u_way (
			.CLK (CLK),
			.nrst (nrst),
			.if_pc (if_pc_u),
			.id_pc (id_pc_u),
			.exe_pc (exe_pc_u),
			.port (way_bus[g])
		);
	end

	////////////////////
	// hit merge
	////////////////////

	bp_hit_select u_hit_select (
		.ways (way_bus),
		.if_prediction (if_prediction),
		.if_pbt (if_pbt),
		.id_present (id_present),
		.exe_hit (exe_hit),
		.exe_way (exe_way),
		.exe_ctr (exe_ctr),
		.exe_pbt (exe_pbt)
	);

	////////////////////
	// outcome, fifo and writes
	////////////////////

	bp_update_ctrl u_update_ctrl (
		.CLK (CLK),
		.nrst (nrst),
		.id_pc (id_pc_u),
		.id_branchtarget (id_branchtarget),
		.id_is_jump (id_is_jump),
		.id_is_btype (id_is_btype),
		.exe_pc (exe_pc_u),
		.exe_z (exe_z),
		.exe_less (exe_less),
		.exe_btype (exe_btype),
		.id_present (id_present),
		.exe_hit (exe_hit),
		.exe_way (exe_way),
		.exe_ctr (exe_ctr),
		.ways (way_bus),
		.exe_correction (exe_correction),
		.exe_cni (exe_cni),
		.flush (flush)
	);

endmodule

// ==== verif/branch_predictor_asserts.sv ====
`timescale 1ns/100ps

module branch_predictor_asserts (
	input logic CLK,
	input logic nrst,
	input logic id_is_jump,
	input logic [1:0] exe_correction,
	input logic flush
);

	////////////////////
	// correction code
	////////////////////

	// 01 is not a legal code
	a_no_code_01: assert property (
		@(posedge CLK) disable iff (!nrst) exe_correction != 2'b01
	) else $error("exe_correction carries the unused code 01");

	////////////////////
	// flush timing
	////////////////////

	// a correction flushes in its own cycle
	a_corr_flush_now: assert property (
		@(posedge CLK) disable iff (!nrst) (exe_correction != bp_pkg::CORR_NONE) |-> flush
	) else $error("correction given without flush in the same cycle");

	// and holds the flush one more cycle
	a_corr_flush_next: assert property (
		@(posedge CLK) disable iff (!nrst) (exe_correction != bp_pkg::CORR_NONE) |=> flush
	) else $error("correction not followed by flush in the next cycle");

	// a jump seen in ID flushes the fetch stage behind it
	a_jump_flush: assert property (
		@(posedge CLK) disable iff (!nrst) id_is_jump |=> flush
	) else $error("jump in ID not followed by flush");

endmodule

bind branch_predictor branch_predictor_asserts u_asserts (.*);

// ==== verif/tb_branch_predictor.sv ====
`timescale 1ns/100ps

module tb_branch_predictor;

	// whole run is about 100 cycles, limit leaves wide margin
	localparam int MAX_CYCLES = 400;

	logic CLK;
	logic nrst;
	logic [bp_pkg::PC_W-1:0] if_pc;
	logic [bp_pkg::PC_W-1:0] id_pc;
	logic [bp_pkg::PC_W-1:0] id_branchtarget;
	logic id_is_jump;
	logic id_is_btype;
	logic [bp_pkg::PC_W-1:0] exe_pc;
	logic exe_z;
	logic exe_less;
	logic [bp_pkg::BTYPE_W-1:0] exe_btype;
	logic if_prediction;
	logic [bp_pkg::PC_W-1:0] if_pbt;
	logic [1:0] exe_correction;
	logic [bp_pkg::PC_W-1:0] exe_pbt;
	logic [bp_pkg::PC_W-1:0] exe_cni;
	logic flush;

	// reference model of the table
	logic m_valid [bp_pkg::NUM_SETS][bp_pkg::NUM_WAYS];
	logic [bp_pkg::TAG_W-1:0] m_tag [bp_pkg::NUM_SETS][bp_pkg::NUM_WAYS];
	logic [bp_pkg::PC_W-1:0] m_tgt [bp_pkg::NUM_SETS][bp_pkg::NUM_WAYS];
	logic [bp_pkg::CTR_W-1:0] m_ctr [bp_pkg::NUM_SETS][bp_pkg::NUM_WAYS];
	logic [1:0] m_ptr [bp_pkg::NUM_SETS];
	logic m_flush_q;

	int seed = 26488;
	int checks = 0;
	int errors = 0;
	int cycle_count = 0;

	branch_predictor dut (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// run limit
	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	////////////////////
	// compare tasks
	////////////////////

	task automatic compare_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_pc(input string what, input logic [bp_pkg::PC_W-1:0] got,
			input logic [bp_pkg::PC_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_corr(input string what, input logic [1:0] got,
			input logic [1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	////////////////////
	// reference model
	////////////////////

	// way holding this pc, -1 on a miss
	function automatic int find_way(input logic [bp_pkg::PC_W-1:0] pc);
		bp_pkg::pc_u p;
		p.raw = pc;
		find_way = -1;
		for (int w = 0; w < bp_pkg::NUM_WAYS; w++) begin
			if (m_valid[p.fields.set][w] && m_tag[p.fields.set][w] == p.fields.tag) begin
				find_way = w;
			end
		end
	endfunction

	// btype msb first: beq bne blt bge bltu bgeu
	function automatic logic branch_taken(input logic [5:0] bt, input logic z,
			input logic less);
		case (bt)
			6'b100000: branch_taken = z;
			6'b010000: branch_taken = !z;
			6'b001000, 6'b000010: branch_taken = less;
			6'b000100, 6'b000001: branch_taken = !less;
			default: branch_taken = 1'b0;
		endcase
	endfunction

	// compare every output, then advance the model past the coming edge
	task automatic settle_and_check;
		bp_pkg::pc_u ep;
		bp_pkg::pc_u dp;
		int iw;
		int ew;
		int dw;
		logic tk;
		logic mis;
		logic [1:0] corr;
		#1;
		ep.raw = exe_pc;
		dp.raw = id_pc;
		iw = find_way(if_pc);
		ew = find_way(exe_pc);
		dw = find_way(id_pc);
		compare_flag("if_prediction", if_prediction, iw >= 0 ? m_ctr[if_pc[3:0]][iw][1] : 1'b0);
		compare_pc("if_pbt", if_pbt, iw >= 0 ? m_tgt[if_pc[3:0]][iw] : '0);
		tk = branch_taken(exe_btype, exe_z, exe_less);
		// a miss in EXE is never checked
		mis = (ew >= 0) && (exe_btype != '0) && (tk != m_ctr[ep.fields.set][ew][1]);
		corr = !mis ? bp_pkg::CORR_NONE : (tk ? bp_pkg::CORR_PBT : bp_pkg::CORR_CNI);
		compare_corr("exe_correction", exe_correction, corr);
		compare_pc("exe_pbt", exe_pbt, ew >= 0 ? m_tgt[ep.fields.set][ew] : '0);
		compare_pc("exe_cni", exe_cni, bp_pkg::PC_W'(exe_pc + 1));
		compare_flag("flush", flush, mis | m_flush_q);
		m_flush_q = mis | id_is_jump;
		// allocation on an ID miss wins over the counter update
		if ((id_is_jump || id_is_btype) && dw < 0) begin
			m_valid[dp.fields.set][m_ptr[dp.fields.set]] = 1'b1;
			m_tag[dp.fields.set][m_ptr[dp.fields.set]] = dp.fields.tag;
			m_tgt[dp.fields.set][m_ptr[dp.fields.set]] = id_branchtarget;
			m_ctr[dp.fields.set][m_ptr[dp.fields.set]] = id_is_jump ? 2'b11 : 2'b01;
			m_ptr[dp.fields.set] = m_ptr[dp.fields.set] + 2'd1;
		end else if (ew >= 0 && exe_btype != '0) begin
			if (tk && m_ctr[ep.fields.set][ew] != 2'b11) begin
				m_ctr[ep.fields.set][ew] = m_ctr[ep.fields.set][ew] + 2'd1;
			end else if (!tk && m_ctr[ep.fields.set][ew] != 2'b00) begin
				m_ctr[ep.fields.set][ew] = m_ctr[ep.fields.set][ew] - 2'd1;
			end
		end
	endtask

	////////////////////
	// drive helpers
	////////////////////

	task automatic clear_inputs;
		if_pc = '0;
		id_pc = '0;
		id_branchtarget = '0;
		id_is_jump = 1'b0;
		id_is_btype = 1'b0;
		exe_pc = '0;
		exe_z = 1'b0;
		exe_less = 1'b0;
		exe_btype = '0;
	endtask

	// inputs change 1 ns after the edge
	task automatic next_cycle;
		@(posedge CLK);
		#1;
		clear_inputs();
	endtask

	task automatic alloc_entry(input logic [9:0] pc, input logic [9:0] tgt, input logic jump);
		next_cycle();
		id_pc = pc;
		id_branchtarget = tgt;
		id_is_jump = jump;
		id_is_btype = !jump;
		settle_and_check();
	endtask

	task automatic lookup(input logic [9:0] pc);
		next_cycle();
		if_pc = pc;
		settle_and_check();
	endtask

	// the flag the type ignores carries the opposite value
	// IF fetches the same pc and shows the counter before this update
	task automatic resolve(input logic [9:0] pc, input logic [5:0] bt, input logic flag);
		next_cycle();
		if_pc = pc;
		exe_pc = pc;
		exe_btype = bt;
		if (bt[5] || bt[4]) begin
			exe_z = flag;
			exe_less = !flag;
		end else begin
			exe_z = !flag;
			exe_less = flag;
		end
		settle_and_check();
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic test_reset;
		for (int i = 0; i < 8; i++) begin
			lookup(10'($random(seed)));
		end
		// taken branch on an empty table, a miss gets no correction
		resolve(10'($random(seed)), 6'b100000, 1'b1);
	endtask

	task automatic test_alloc;
		bp_pkg::pc_u p;
		p.raw = {6'($random(seed)), 4'd0};
		alloc_entry(p.raw, 10'($random(seed)), 1'b0);
		lookup(p.raw);
		p.raw = {6'($random(seed)), 4'd1};
		alloc_entry(p.raw, 10'($random(seed)), 1'b1);
		// jump predicts taken and flushes here
		lookup(p.raw);
	endtask

	task automatic test_resolve;
		bp_pkg::pc_u p;
		logic [5:0] bt;
		logic flag;
		for (int n = 0; n < 12; n++) begin
			bt = 6'b100000 >> (n / 2);
			flag = (n % 2) == 1;
			p.fields.set = 4'(2 + n);
			p.fields.tag = 6'($random(seed));
			alloc_entry(p.raw, 10'($random(seed)), 1'b0);
			resolve(p.raw, bt, flag);
			resolve(p.raw, bt, !flag);
			// second flush cycle
			next_cycle();
			settle_and_check();
			lookup(p.raw);
		end
	endtask

	task automatic test_fifo;
		bp_pkg::pc_u p;
		logic [5:0] base;
		base = 6'($random(seed));
		p.fields.set = 4'd15;
		for (int i = 0; i < 5; i++) begin
			p.fields.tag = base + 6'(i);
			alloc_entry(p.raw, 10'($random(seed)), 1'b0);
		end
		// first tag gone, the other four still there
		for (int i = 0; i < 5; i++) begin
			p.fields.tag = base + 6'(i);
			lookup(p.raw);
		end
		// repeat of a present tag leaves the pointer alone
		p.fields.tag = base + 6'd2;
		alloc_entry(p.raw, 10'($random(seed)), 1'b0);
		p.fields.tag = base + 6'd5;
		alloc_entry(p.raw, 10'($random(seed)), 1'b0);
		p.fields.tag = base + 6'd1;
		lookup(p.raw);
		compare_pc("if_pbt of evicted tag", if_pbt, '0);
		p.fields.tag = base + 6'd2;
		lookup(p.raw);
	endtask

	task automatic test_priority;
		bp_pkg::pc_u pa;
		bp_pkg::pc_u pb;
		pa.fields.set = 4'd14;
		pa.fields.tag = 6'($random(seed));
		pb = pa;
		pb.fields.tag = pa.fields.tag ^ 6'h01;
		alloc_entry(pa.raw, 10'($random(seed)), 1'b0);
		// new branch in ID while the first resolves taken
		next_cycle();
		id_pc = pb.raw;
		id_branchtarget = 10'($random(seed));
		id_is_btype = 1'b1;
		exe_pc = pa.raw;
		exe_btype = 6'b100000;
		exe_z = 1'b1;
		settle_and_check();
		lookup(pa.raw);
		compare_flag("if_prediction after clash", if_prediction, 1'b0);
		lookup(pb.raw);
		resolve(pa.raw, 6'b100000, 1'b1);
		lookup(pa.raw);
	endtask

	initial begin
		nrst = 1'b0;
		clear_inputs();
		for (int s = 0; s < bp_pkg::NUM_SETS; s++) begin
			m_ptr[s] = 2'd0;
			for (int w = 0; w < bp_pkg::NUM_WAYS; w++) begin
				m_valid[s][w] = 1'b0;
			end
		end
		m_flush_q = 1'b0;
		repeat (3) @(posedge CLK);
		#1;
		nrst = 1'b1;
		test_reset();
		test_alloc();
		test_resolve();
		test_fifo();
		test_priority();
		next_cycle();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
design/bp_pkg.sv
design/bp_way_if.sv
design/bp_way.sv
design/bp_hit_select.sv
design/bp_update_ctrl.sv
design/branch_predictor.sv
verif/branch_predictor_asserts.sv
verif/tb_branch_predictor.sv
